// ==== common/lsu_pkg.sv ====
// Shared widths, counts and types of the load/store issue stage.
// Every stage module imports this package inside its body and uses
// scoped names for the types on its ports.

`default_nettype none

package lsu_pkg;

	// Hardware threads and lanes
	localparam int thread_count = 4;
	localparam int thread_idx_w = $clog2(thread_count);
	localparam int lane_count = 8;
	localparam int lane_width = 32;
	localparam int lane_idx_w = $clog2(lane_count);

	// Data cache line geometry
	localparam int line_bytes = 32;
	localparam int line_width = line_bytes * 8;
	localparam int offset_w = $clog2(line_bytes);
	localparam int line_addr_w = 32 - offset_w;

	// Wide enough to hold a byte count up to twice the line length,
	// so offset plus span never wraps
	localparam int span_w = offset_w + 2;

	// Per-thread request queue sizing
	localparam int queue_depth = 4;
	localparam int almost_full_threshold = 1;
	localparam int queue_ptr_w = $clog2(queue_depth);
	localparam int queue_count_w = $clog2(queue_depth + 1);

	// Entry point of the misaligned access handler
	localparam logic [31:0] misalign_handler_pc = 32'h0000_0400;

	typedef logic [thread_idx_w-1:0] thread_id_t;
	typedef logic [lane_count-1:0] lane_mask_t;
	typedef logic [line_bytes-1:0] store_mask_t;

	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} mem_size_t;

	typedef struct packed {
		logic [line_addr_w-1:0] line_addr;
		logic [offset_w-1:0] offset;
	} dcache_address_t;

	// The aligner fills a line at byte, halfword or word granularity
	typedef union packed {
		logic [line_bytes-1:0][7:0] bytes;
		logic [line_bytes/2-1:0][15:0] halfs;
		logic [line_width/lane_width-1:0][lane_width-1:0] words;
	} dcache_line_u;

	typedef struct packed {
		logic [31:0] pc;
		thread_id_t thread_id;
		mem_size_t size;
		logic is_vector;
		logic is_store;
	} mem_inst_t;

	typedef struct packed {
		mem_inst_t inst;
		dcache_address_t address;
		logic [lane_count-1:0][lane_width-1:0] operand;
		lane_mask_t lane_mask;
	} issue_op_t;

	typedef struct packed {
		mem_inst_t inst;
		dcache_address_t address;
		dcache_line_u store_value;
		store_mask_t store_mask;
		lane_mask_t lane_mask;
	} mem_request_t;

	// Bytes touched by one access, which is also its required alignment.
	// A vector access covers one element per lane
	function automatic logic [span_w-1:0] access_bytes(mem_size_t size, logic is_vector);
		logic [span_w-1:0] elem_bytes;
		case (size)
			size_byte: elem_bytes = span_w'(1);
			size_half: elem_bytes = span_w'(2);
			default: elem_bytes = span_w'(4);
		endcase
		return is_vector ? (elem_bytes << lane_idx_w) : elem_bytes;
	endfunction

endpackage

`default_nettype wire

// ==== src/mem_op_decoder.sv ====
// Front end of the issue stage. Filters requests of rolled-back threads,
// checks address alignment and either enqueues the request or fires a
// registered rollback towards the misalignment handler.

`timescale 1ns/1ps
`default_nettype none

module mem_op_decoder (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               opf_valid,
	input  lsu_pkg::issue_op_t                 opf_op,
	input  logic [lsu_pkg::thread_count-1:0]   rollback_valid,
	output logic                               enqueue,
	output logic                               rollback_en,
	output logic [31:0]                        rollback_pc,
	output lsu_pkg::thread_id_t                rollback_thread_id
);

	import lsu_pkg::*;

	logic request_valid;
	logic [span_w-1:0] span;
	logic [offset_w-1:0] align_mask;
	logic misaligned;
	logic take_rollback;

	// A thread under rollback this cycle drops whatever it issued
	assign request_valid = opf_valid & ~rollback_valid[opf_op.inst.thread_id];

	// Required alignment equals the access span, always a power of two.
	// A scalar byte gives an all-zero mask and is never misaligned
	assign span = access_bytes(opf_op.inst.size, opf_op.inst.is_vector);
	assign align_mask = offset_w'(span - 1'b1);
	assign misaligned = |(opf_op.address.offset & align_mask);

	// The misaligned request itself is held back from the queues
	assign enqueue = request_valid & ~misaligned;
	assign take_rollback = request_valid & misaligned;

	// One-cycle rollback pulse in the cycle after the bad request
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rollback_en <= 1'b0;
		end else begin
			rollback_en <= take_rollback;
		end
	end

	// Target and thread only matter while rollback_en is high
	always_ff @(posedge clk) begin
		if (take_rollback) begin
			rollback_pc <= misalign_handler_pc;
			rollback_thread_id <= opf_op.inst.thread_id;
		end
	end

endmodule

`default_nettype wire

// ==== src/store_data_aligner.sv ====
// Turns an operand fetch request into a queued memory request. Store data
// is replicated over a full cache line and a byte store mask marks the
// bytes the access actually writes.

`timescale 1ns/1ps
`default_nettype none

module store_data_aligner (
	input  lsu_pkg::issue_op_t     opf_op,
	output lsu_pkg::mem_request_t  request
);

	import lsu_pkg::*;

	logic [lane_count-1:0][lane_width-1:0] elems;
	dcache_line_u line;
	logic [span_w-1:0] span;
	logic [span_w-1:0] first_byte;
	logic [span_w-1:0] end_byte;
	store_mask_t mask;

	// A scalar access repeats lane 0 in every slot, a vector keeps
	// one element per lane
	always_comb begin
		for (int l = 0; l < lane_count; l++) begin
			elems[l] = opf_op.inst.is_vector ? opf_op.operand[l] : opf_op.operand[0];
		end
	end

	// Only the low element of each lane is stored, and the packed
	// elements are tiled until the line is full
	always_comb begin
		line = '0;
		case (opf_op.inst.size)
			size_byte: begin
				for (int i = 0; i < line_bytes; i++) begin
					line.bytes[i] = elems[i % lane_count][7:0];
				end
			end
			size_half: begin
				for (int i = 0; i < line_bytes / 2; i++) begin
					line.halfs[i] = elems[i % lane_count][15:0];
				end
			end
			default: begin
				for (int i = 0; i < line_width / lane_width; i++) begin
					line.words[i] = elems[i % lane_count];
				end
			end
		endcase
	end

	// Mask covers [offset, offset + span). Misaligned spans may run off the
	// line here, but the decoder never enqueues those
	assign span = access_bytes(opf_op.inst.size, opf_op.inst.is_vector);
	assign first_byte = span_w'(opf_op.address.offset);
	assign end_byte = first_byte + span;

	always_comb begin
		for (int i = 0; i < line_bytes; i++) begin
			mask[i] = (span_w'(i) >= first_byte) && (span_w'(i) < end_byte);
		end
	end

	always_comb begin
		request.inst = opf_op.inst;
		request.address = opf_op.address;
		request.store_value = line;
		request.store_mask = mask;
		request.lane_mask = opf_op.lane_mask;
	end

endmodule

`default_nettype wire

// ==== request_queue/thread_request_fifo.sv ====
// Small first-word-fall-through request queue for a single thread.
// The head entry is always visible, pop consumes it at the clock edge.
// A push into a full queue or a pop from an empty one is ignored.

`timescale 1ns/1ps
`default_nettype none

module thread_request_fifo (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   push,
	input  lsu_pkg::mem_request_t  push_req,
	input  logic                   pop,
	output lsu_pkg::mem_request_t  head,
	output logic                   empty,
	output logic                   almost_full
);

	import lsu_pkg::*;

	mem_request_t entries [queue_depth];
	logic [queue_ptr_w-1:0] wr_ptr;
	logic [queue_ptr_w-1:0] rd_ptr;
	logic [queue_count_w-1:0] count;
	logic do_push;
	logic do_pop;

	// Wraps explicitly so the depth need not be a power of two
	function automatic logic [queue_ptr_w-1:0] next_ptr(logic [queue_ptr_w-1:0] ptr);
		return (ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_push = push && (count != queue_count_w'(queue_depth));
	assign do_pop = pop && (count != '0);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Simultaneous push and pop leave the count unchanged
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr] <= push_req;
		end
	end

	assign head = entries[rd_ptr];
	assign empty = (count == '0);

	// Flags follow the registered count, so they lag a push by one cycle
	assign almost_full = (count >= queue_count_w'(queue_depth - almost_full_threshold));

endmodule

`default_nettype wire

// ==== request_queue/thread_request_queues.sv ====
// Bank of per-thread request queues. The enqueue strobe is steered by the
// request's thread, stage 2 pops each queue through its own dequeue bit,
// and the empty flags feed the valid and no-pending masks.

`timescale 1ns/1ps
`default_nettype none

module thread_request_queues (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  logic                                                 enqueue,
	input  lsu_pkg::mem_request_t                                request,
	input  logic [lsu_pkg::thread_count-1:0]                     dequeue,
	output logic [lsu_pkg::thread_count-1:0]                     req_valid,
	output lsu_pkg::mem_request_t [lsu_pkg::thread_count-1:0]    req,
	output logic [lsu_pkg::thread_count-1:0]                     almost_full,
	output logic [lsu_pkg::thread_count-1:0]                     s1_no_ls_pending
);

	import lsu_pkg::*;

	for (genvar t = 0; t < thread_count; t++) begin : g_thread
		logic push;
		logic empty;

		// Only the queue owned by the request's thread takes it
		assign push = enqueue && (request.inst.thread_id == thread_id_t'(t));

		thread_request_fifo fifo0 (
			.clk         (clk),
			.reset       (reset),
			.push        (push),
			.push_req    (request),
			.pop         (dequeue[t]),
			.head        (req[t]),
			.empty       (empty),
			.almost_full (almost_full[t])
		);

		assign req_valid[t] = ~empty;
		// Synchronization logic waits until this goes high
		assign s1_no_ls_pending[t] = empty;
	end

endmodule

`default_nettype wire

// ==== src/miss_recycle_buffer.sv ====
// One-entry buffer per thread for requests that missed in stage 3.
// The entry is offered back to stage 2 until stage 2 reports it recycled.
// A new miss in the same cycle as recycled replaces the entry.

`timescale 1ns/1ps
`default_nettype none

module miss_recycle_buffer (
	input  logic                                                 clk,
	input  logic                                                 reset,
	input  logic                                                 miss_valid,
	input  lsu_pkg::mem_request_t                                miss_req,
	input  logic [lsu_pkg::thread_count-1:0]                     recycled,
	output logic [lsu_pkg::thread_count-1:0]                     recycle_valid,
	output lsu_pkg::mem_request_t [lsu_pkg::thread_count-1:0]    recycle_req,
	output logic [lsu_pkg::thread_count-1:0]                     miss_no_ls_pending
);

	import lsu_pkg::*;

	for (genvar t = 0; t < thread_count; t++) begin : g_thread
		logic capture;
		logic held;
		mem_request_t held_req;

		assign capture = miss_valid && (miss_req.inst.thread_id == thread_id_t'(t));

		// Capture has priority over recycled
		always_ff @(posedge clk, posedge reset) begin
			if (reset) begin
				held <= 1'b0;
			end else if (capture) begin
				held <= 1'b1;
			end else if (recycled[t]) begin
				held <= 1'b0;
			end
		end

		always_ff @(posedge clk) begin
			if (capture) begin
				held_req <= miss_req;
			end
		end

		assign recycle_valid[t] = held;
		assign recycle_req[t] = held_req;
	end

	// A thread is clear once nothing waits in its buffer
	assign miss_no_ls_pending = ~recycle_valid;

endmodule

`default_nettype wire

// ==== src/lsu_issue_stage.sv ====
// First stage of the load/store unit. Takes requests from operand fetch,
// checks alignment, aligns store data, queues requests per thread for
// stage 2 and holds stage 3 misses for replay.

`timescale 1ns/1ps
`default_nettype none

module lsu_issue_stage (
	input  logic                                                 clk,
	input  logic                                                 reset,

	// Operand fetch and rollback handler
	input  logic                                                 opf_valid,
	input  lsu_pkg::issue_op_t                                   opf_op,
	input  logic [lsu_pkg::thread_count-1:0]                     rollback_valid,

	// Stage 2 request side
	input  logic [lsu_pkg::thread_count-1:0]                     dequeue,
	output logic [lsu_pkg::thread_count-1:0]                     req_valid,
	output lsu_pkg::mem_request_t [lsu_pkg::thread_count-1:0]    req,
	output logic [lsu_pkg::thread_count-1:0]                     almost_full,
	output logic [lsu_pkg::thread_count-1:0]                     s1_no_ls_pending,

	// Stage 3 misses and their replay towards stage 2
	input  logic                                                 miss_valid,
	input  lsu_pkg::mem_request_t                                miss_req,
	input  logic [lsu_pkg::thread_count-1:0]                     recycled,
	output logic [lsu_pkg::thread_count-1:0]                     recycle_valid,
	output lsu_pkg::mem_request_t [lsu_pkg::thread_count-1:0]    recycle_req,
	output logic [lsu_pkg::thread_count-1:0]                     miss_no_ls_pending,

	// Rollback towards the misalignment handler
	output logic                                                 rollback_en,
	output logic [31:0]                                          rollback_pc,
	output lsu_pkg::thread_id_t                                  rollback_thread_id
);

	import lsu_pkg::*;

	logic enqueue;
	mem_request_t request;

	mem_op_decoder decoder0 (
		.clk                (clk),
		.reset              (reset),
		.opf_valid          (opf_valid),
		.opf_op             (opf_op),
		.rollback_valid     (rollback_valid),
		.enqueue            (enqueue),
		.rollback_en        (rollback_en),
		.rollback_pc        (rollback_pc),
		.rollback_thread_id (rollback_thread_id)
	);

	// Builds the request in the same cycle the decoder judges it
	store_data_aligner aligner0 (
		.opf_op  (opf_op),
		.request (request)
	);

	thread_request_queues queues0 (
		.clk              (clk),
		.reset            (reset),
		.enqueue          (enqueue),
		.request          (request),
		.dequeue          (dequeue),
		.req_valid        (req_valid),
		.req              (req),
		.almost_full      (almost_full),
		.s1_no_ls_pending (s1_no_ls_pending)
	);

	miss_recycle_buffer recycle0 (
		.clk                (clk),
		.reset              (reset),
		.miss_valid         (miss_valid),
		.miss_req           (miss_req),
		.recycled           (recycled),
		.recycle_valid      (recycle_valid),
		.recycle_req        (recycle_req),
		.miss_no_ls_pending (miss_no_ls_pending)
	);

endmodule

`default_nettype wire

// ==== testbench/lsu_issue_stage_tb.sv ====
// Self-checking testbench of the load/store issue stage.
// Sends scalar, vector, misaligned, rolled-back and missed requests and
// compares every queue, rollback and recycle output with a reference model.

`timescale 1ns/1ps
`default_nettype none

module lsu_issue_stage_tb;

	import lsu_pkg::*;

	localparam int clk_period = 4;
	// Upper bound on the requests and misses sent by the tests below
	localparam int num_requests = 32;
	localparam int watchdog_cycles = num_requests * 20 + 100;

	logic clk = 1'b0;
	logic reset;
	logic opf_valid;
	issue_op_t opf_op;
	logic [thread_count-1:0] rollback_valid;
	logic [thread_count-1:0] dequeue;
	logic [thread_count-1:0] req_valid;
	mem_request_t [thread_count-1:0] req;
	logic [thread_count-1:0] almost_full;
	logic [thread_count-1:0] s1_no_ls_pending;
	logic miss_valid;
	mem_request_t miss_req;
	logic [thread_count-1:0] recycled;
	logic [thread_count-1:0] recycle_valid;
	mem_request_t [thread_count-1:0] recycle_req;
	logic [thread_count-1:0] miss_no_ls_pending;
	logic rollback_en;
	logic [31:0] rollback_pc;
	thread_id_t rollback_thread_id;
	logic [31:0] rng_state = 32'hb98;

	// Reference model, one small circular queue and one held miss per thread
	mem_request_t model_mem [thread_count][queue_depth];
	int model_head [thread_count];
	int model_count [thread_count];
	logic held [thread_count];
	mem_request_t held_req [thread_count];

	lsu_issue_stage dut0 (
		.clk (clk), .reset (reset), .opf_valid (opf_valid), .opf_op (opf_op),
		.rollback_valid (rollback_valid), .dequeue (dequeue), .req_valid (req_valid),
		.req (req), .almost_full (almost_full), .s1_no_ls_pending (s1_no_ls_pending),
		.miss_valid (miss_valid), .miss_req (miss_req), .recycled (recycled),
		.recycle_valid (recycle_valid), .recycle_req (recycle_req),
		.miss_no_ls_pending (miss_no_ls_pending), .rollback_en (rollback_en),
		.rollback_pc (rollback_pc), .rollback_thread_id (rollback_thread_id)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1);
	endtask

	// A rollback is a single-cycle pulse
	rollback_pulse: assert property (@(posedge clk) disable iff (reset) rollback_en |=> !rollback_en)
		else abort_run("rollback_en stayed high for more than one cycle");

	initial begin
		#(watchdog_cycles * clk_period);
		abort_run("Timeout, the tests did not finish in the expected time");
	end

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic logic [thread_count-1:0] thread_bit(thread_id_t t);
		return thread_count'(1) << t;
	endfunction

	function automatic int elem_bytes(mem_size_t size);
		return (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
	endfunction

	// A vector covers one element per lane and must align to that span
	function automatic int span_bytes(mem_size_t size, logic is_vector);
		return is_vector ? elem_bytes(size) * lane_count : elem_bytes(size);
	endfunction

	function automatic issue_op_t make_op(mem_size_t size, logic is_vector, thread_id_t tid,
			logic aligned);
		issue_op_t op;
		int span;
		int offs;
		op.inst.pc = next_rand();
		op.inst.thread_id = tid;
		op.inst.size = size;
		op.inst.is_vector = is_vector;
		op.inst.is_store = 1'b1;
		op.address.line_addr = line_addr_w'(next_rand());
		for (int l = 0; l < lane_count; l++) begin
			op.operand[l] = next_rand();
		end
		op.lane_mask = lane_mask_t'(next_rand());
		span = span_bytes(size, is_vector);
		offs = int'(next_rand() % line_bytes);
		// Misaligned cases always have a span of two or more, so an odd offset breaks them
		offs = aligned ? offs - (offs % span) : (offs | 1);
		op.address.offset = offset_w'(offs);
		return op;
	endfunction

	// Byte b of the line holds byte (b mod size) of element b / size, taken
	// from lane 0 for a scalar or from lane (b / size) mod lane_count for a vector
	function automatic mem_request_t expected_request(issue_op_t op);
		mem_request_t r;
		int esize;
		int span;
		int lane;
		esize = elem_bytes(op.inst.size);
		span = span_bytes(op.inst.size, op.inst.is_vector);
		r.inst = op.inst;
		r.address = op.address;
		r.lane_mask = op.lane_mask;
		for (int b = 0; b < line_bytes; b++) begin
			lane = op.inst.is_vector ? (b / esize) % lane_count : 0;
			r.store_value.bytes[b] = op.operand[lane][8 * (b % esize) +: 8];
			r.store_mask[b] = (b >= int'(op.address.offset)) && (b < int'(op.address.offset) + span);
		end
		return r;
	endfunction

	task automatic compare_field(string name, logic [line_width-1:0] exp, logic [line_width-1:0] act);
		assert (exp === act)
			else abort_run($sformatf("Error %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic compare_request(string name, mem_request_t exp, mem_request_t act);
		compare_field({name, ".inst"}, exp.inst, act.inst);
		compare_field({name, ".address"}, exp.address, act.address);
		compare_field({name, ".store_value"}, exp.store_value, act.store_value);
		compare_field({name, ".store_mask"}, exp.store_mask, act.store_mask);
		compare_field({name, ".lane_mask"}, exp.lane_mask, act.lane_mask);
	endtask

	// Queue and recycle outputs of every thread against the model
	task automatic check_all();
		for (int t = 0; t < thread_count; t++) begin
			compare_field($sformatf("req_valid[%0d]", t), model_count[t] != 0, req_valid[t]);
			compare_field($sformatf("s1_no_ls_pending[%0d]", t), model_count[t] == 0,
				s1_no_ls_pending[t]);
			compare_field($sformatf("almost_full[%0d]", t),
				model_count[t] >= queue_depth - almost_full_threshold, almost_full[t]);
			if (model_count[t] != 0) begin
				compare_request($sformatf("req[%0d]", t), model_mem[t][model_head[t]], req[t]);
			end
			compare_field($sformatf("recycle_valid[%0d]", t), held[t], recycle_valid[t]);
			compare_field($sformatf("miss_no_ls_pending[%0d]", t), !held[t], miss_no_ls_pending[t]);
			if (held[t]) begin
				compare_request($sformatf("recycle_req[%0d]", t), held_req[t], recycle_req[t]);
			end
		end
	endtask

	task automatic check_rollback(logic exp_en, thread_id_t tid);
		compare_field("rollback_en", exp_en, rollback_en);
		if (exp_en) begin
			compare_field("rollback_pc", misalign_handler_pc, rollback_pc);
			compare_field("rollback_thread_id", tid, rollback_thread_id);
		end
	endtask

	// One request for one cycle, then the rollback pulse and its end are checked
	task automatic send_request(issue_op_t op, logic [thread_count-1:0] rb_mask);
		thread_id_t tid;
		logic bad;
		logic masked;
		tid = op.inst.thread_id;
		bad = (int'(op.address.offset) % span_bytes(op.inst.size, op.inst.is_vector)) != 0;
		masked = rb_mask[tid];
		@(posedge clk);
		opf_valid <= 1'b1;
		opf_op <= op;
		rollback_valid <= rb_mask;
		@(posedge clk);
		opf_valid <= 1'b0;
		rollback_valid <= '0;
		if (!masked && !bad && model_count[tid] < queue_depth) begin
			model_mem[tid][(model_head[tid] + model_count[tid]) % queue_depth] = expected_request(op);
			model_count[tid]++;
		end
		@(negedge clk);
		check_all();
		check_rollback(!masked && bad, tid);
		@(negedge clk);
		check_rollback(1'b0, tid);
	endtask

	task automatic dequeue_thread(thread_id_t t);
		@(posedge clk);
		dequeue <= thread_bit(t);
		@(posedge clk);
		dequeue <= '0;
		// A dequeue of an empty queue is ignored
		if (model_count[t] != 0) begin
			model_head[t] = (model_head[t] + 1) % queue_depth;
			model_count[t]--;
		end
		@(negedge clk);
		check_all();
	endtask

	task automatic drive_stage3(logic mv, mem_request_t r, logic [thread_count-1:0] rec);
		@(posedge clk);
		miss_valid <= mv;
		miss_req <= r;
		recycled <= rec;
		@(posedge clk);
		miss_valid <= 1'b0;
		recycled <= '0;
		for (int t = 0; t < thread_count; t++) begin
			if (mv && r.inst.thread_id == thread_id_t'(t)) begin
				held[t] = 1'b1;
				held_req[t] = r;
			end else if (rec[t]) begin
				held[t] = 1'b0;
			end
		end
		@(negedge clk);
		check_all();
	endtask

	initial begin
		thread_id_t t;
		thread_id_t u;
		mem_request_t r;
		reset <= 1'b1;
		opf_valid <= 1'b0;
		opf_op <= '0;
		rollback_valid <= '0;
		dequeue <= '0;
		miss_valid <= 1'b0;
		miss_req <= '0;
		recycled <= '0;
		for (int i = 0; i < thread_count; i++) begin
			model_head[i] = 0;
			model_count[i] = 0;
			held[i] = 1'b0;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_all();
		check_rollback(1'b0, '0);

		// Aligned scalar then vector stores of each size, each taken back out
		for (int v = 0; v < 2; v++) begin
			for (int s = 0; s < 3; s++) begin
				for (int k = 0; k < 2; k++) begin
					t = thread_id_t'(next_rand());
					send_request(make_op(mem_size_t'(s), v != 0, t, 1'b1), '0);
					dequeue_thread(t);
				end
			end
		end

		// Misaligned scalar halfword and word, then misaligned vectors
		for (int s = 1; s < 3; s++) begin
			send_request(make_op(mem_size_t'(s), 1'b0, thread_id_t'(next_rand()), 1'b0), '0);
		end
		for (int s = 0; s < 3; s++) begin
			send_request(make_op(mem_size_t'(s), 1'b1, thread_id_t'(next_rand()), 1'b0), '0);
		end

		// Three requests fill thread t up to almost full while u holds one
		t = thread_id_t'(next_rand());
		u = thread_id_t'(t + 1);
		for (int k = 0; k < 3; k++) begin
			send_request(make_op(mem_size_t'(k), k[0], t, 1'b1), '0);
		end
		send_request(make_op(size_word, 1'b0, u, 1'b1), '0);
		for (int k = 0; k < 4; k++) begin
			dequeue_thread(t);
		end
		dequeue_thread(u);

		// Rollback of the own thread drops the request, of another thread does not
		send_request(make_op(size_word, 1'b0, t, 1'b1), thread_bit(t));
		send_request(make_op(size_half, 1'b1, t, 1'b0), thread_bit(t));
		send_request(make_op(size_byte, 1'b1, t, 1'b1), thread_bit(u));
		dequeue_thread(t);

		// Recycle buffer capture, release and a miss racing a release
		r = expected_request(make_op(size_word, 1'b1, t, 1'b1));
		drive_stage3(1'b1, r, '0);
		r = expected_request(make_op(size_half, 1'b0, u, 1'b1));
		drive_stage3(1'b1, r, '0);
		drive_stage3(1'b0, r, thread_bit(t));
		r = expected_request(make_op(size_byte, 1'b0, t, 1'b1));
		drive_stage3(1'b1, r, '0);
		r = expected_request(make_op(size_word, 1'b0, t, 1'b1));
		drive_stage3(1'b1, r, thread_bit(t));
		drive_stage3(1'b0, r, thread_bit(t) | thread_bit(u));

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lsu_issue_stage.f ====
common/lsu_pkg.sv
src/mem_op_decoder.sv
src/store_data_aligner.sv
request_queue/thread_request_fifo.sv
request_queue/thread_request_queues.sv
src/miss_recycle_buffer.sv
src/lsu_issue_stage.sv
testbench/lsu_issue_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module lsu_issue_stage_tb \
	-Mdir obj_dir \
	-f lsu_issue_stage.f; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vlsu_issue_stage_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
echo "Simulation passed"
exit 0
